//--- src/fpa_pkg.sv
// shared widths, enums and structs for the mantissa arithmetic unit
// every block refers to these by scoped name through fpa_pkg::
// bit 0 is the most significant bit throughout

`default_nettype none

package fpa_pkg;

	// mantissa and data bus widths
	localparam int mant_w = 40;
	localparam int word_w = 16;
	// the low piece is what is left after two full words
	localparam int lo_w = mant_w - 2 * word_w;

	// normalize shift counter
	localparam int cnt_w = 6;
	// never shift more than the mantissa allows
	localparam logic [cnt_w-1:0] norm_max = cnt_w'(mant_w - 1);

	// operations run by the sequencer
	typedef enum logic [1:0] {
		op_add  = 2'd0,
		op_sub  = 2'd1,
		op_neg  = 2'd2,
		op_norm = 2'd3
	} fpa_op_e;

	// sequencer states
	typedef enum logic [1:0] {
		st_idle  = 2'd0,
		st_arith = 2'd1,
		st_shift = 2'd2,
		st_flag  = 2'd3
	} fpa_state_e;

	// mantissa piece select for loads and for the zp bus
	// part_lo sits left-justified in the word with the low byte zero
	typedef enum logic [1:0] {
		part_hi  = 2'd0,
		part_mid = 2'd1,
		part_lo  = 2'd2
	} fpa_part_e;

	// per-cycle strobes from the sequencer
	typedef struct packed {
		// T takes the adder output
		logic t_sum;
		// T shifts left one place with zero fill
		logic t_shl;
		// adder forms T minus C
		logic sub;
		// adder forms zero minus T
		logic neg_t;
		// flag latch enable
		logic flag_ld;
		// arithmetic op so v and c are meaningful
		logic ar;
	} fpa_ctl_s;

	// result flags as seen on the zp side
	typedef struct packed {
		logic z;
		logic m;
		logic v;
		logic c;
	} fpa_flags_s;

	// group carries out of the adder
	// c0 is the carry above bit 0
	typedef struct packed {
		logic c0;
		logic c16;
		logic c32;
	} fpa_cout_s;

endpackage

`default_nettype wire

//--- src/fpa_ctl.sv
// sequencer for the mantissa unit
// turns start/op into register strobes, runs the normalize loop
// and gates the external load pulses while an operation is in flight

`timescale 1ns/100ps
`default_nettype none

module fpa_ctl (
	input  wire logic                      clk_sys,
	input  wire logic                      rst_n,
	input  wire logic                      start,
	input  wire fpa_pkg::fpa_op_e          op,
	input  wire logic                      t_ld,
	input  wire logic                      c_ld,
	input  wire logic                      t0,
	input  wire logic                      t1,
	input  wire logic                      t_zero,
	output fpa_pkg::fpa_ctl_s              ctl,
	output logic                           t_wr,
	output logic                           c_wr,
	output logic                           busy,
	output logic                           done,
	output logic [fpa_pkg::cnt_w-1:0]      norm_cnt
);

	fpa_pkg::fpa_state_e state;
	fpa_pkg::fpa_state_e state_nx;
	fpa_pkg::fpa_op_e op_q;
	logic [fpa_pkg::cnt_w-1:0] cnt;
	logic shift_ok;
	logic arith;

	// add, sub and neg all go through the adder
	assign arith = (op_q != fpa_pkg::op_norm);

	// keep shifting while the top two bits agree
	// an all zero T would never stop, so it is cut off here
	assign shift_ok = (t0 == t1) && !t_zero && (cnt < fpa_pkg::norm_max);

	always_comb begin
		state_nx = state;
		ctl = '0;
		case (state)
			fpa_pkg::st_idle: begin
				if (start) begin
					state_nx = (op == fpa_pkg::op_norm) ? fpa_pkg::st_shift : fpa_pkg::st_arith;
				end
			end
			fpa_pkg::st_arith: begin
				// single adder cycle, T takes the sum at the end of it
				ctl.t_sum = 1'b1;
				ctl.sub = (op_q == fpa_pkg::op_sub);
				ctl.neg_t = (op_q == fpa_pkg::op_neg);
				// zp side grabs the carries while the adder sees the old T
				ctl.ar = 1'b1;
				state_nx = fpa_pkg::st_flag;
			end
			fpa_pkg::st_shift: begin
				if (shift_ok) begin
					ctl.t_shl = 1'b1;
				end else begin
					state_nx = fpa_pkg::st_flag;
				end
			end
			fpa_pkg::st_flag: begin
				ctl.flag_ld = 1'b1;
				ctl.ar = arith;
				state_nx = fpa_pkg::st_idle;
			end
			default: state_nx = fpa_pkg::st_idle;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state <= fpa_pkg::st_idle;
			op_q <= fpa_pkg::op_add;
			cnt <= '0;
			done <= 1'b0;
		end else begin
			state <= state_nx;
			// one cycle pulse once the flags are in
			done <= (state == fpa_pkg::st_flag);
			if (state == fpa_pkg::st_idle && start) begin
				op_q <= op;
				// count restarts with every operation
				cnt <= '0;
			end else if (ctl.t_shl) begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	assign busy = (state != fpa_pkg::st_idle);
	assign norm_cnt = cnt;

	// external loads only land while idle
	assign t_wr = t_ld && (state == fpa_pkg::st_idle);
	assign c_wr = c_ld && (state == fpa_pkg::st_idle);

endmodule

`default_nettype wire

//--- src/fpa_regs.sv
// T and C mantissa registers
// pieces come in from the 16-bit w bus, T also takes the adder sum
// or shifts left for normalize; t_zero goes back to the sequencer

`timescale 1ns/100ps
`default_nettype none

module fpa_regs (
	input  wire logic                          clk_sys,
	input  wire logic                          rst_n,
	input  wire fpa_pkg::fpa_ctl_s             ctl,
	input  wire logic                          t_wr,
	input  wire logic                          c_wr,
	input  wire logic [0:fpa_pkg::word_w-1]    w,
	input  wire fpa_pkg::fpa_part_e            w_part,
	input  wire logic [0:fpa_pkg::mant_w-1]    sum,
	output logic [0:fpa_pkg::mant_w-1]         t,
	output logic [0:fpa_pkg::mant_w-1]         c,
	output logic                               t_zero
);

	// drop one word piece into a mantissa, rest untouched
	function automatic logic [0:fpa_pkg::mant_w-1] put_piece(
		input logic [0:fpa_pkg::mant_w-1] r,
		input logic [0:fpa_pkg::word_w-1] d,
		input fpa_pkg::fpa_part_e p
	);
		logic [0:fpa_pkg::mant_w-1] q;
		q = r;
		case (p)
			// bits 0..15
			fpa_pkg::part_hi: q[0:fpa_pkg::word_w-1] = d;
			// bits 16..31
			fpa_pkg::part_mid: q[fpa_pkg::word_w:2*fpa_pkg::word_w-1] = d;
			// bits 32..39 from the left end of the word
			fpa_pkg::part_lo: q[2*fpa_pkg::word_w:fpa_pkg::mant_w-1] = d[0:fpa_pkg::lo_w-1];
			// unused select, no write
			default: q = r;
		endcase
		return q;
	endfunction

	// k bus into T
	logic [0:fpa_pkg::mant_w-1] t_k;
	logic t_en;

	always_comb begin
		if (ctl.t_sum) begin
			t_k = sum;
		end else if (ctl.t_shl) begin
			// one place left, zero into bit 39
			t_k = {t[1:fpa_pkg::mant_w-1], 1'b0};
		end else begin
			t_k = put_piece(t, w, w_part);
		end
	end

	// sequencer never overlaps a load with sum or shift
	assign t_en = ctl.t_sum | ctl.t_shl | t_wr;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			t <= '0;
		end else if (t_en) begin
			t <= t_k;
		end
	end

	// C is only ever written from the bus
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			c <= '0;
		end else if (c_wr) begin
			c <= put_piece(c, w, w_part);
		end
	end

	// stops normalize on a zero mantissa
	assign t_zero = ~|t;

endmodule

`default_nettype wire

//--- src/fpalu.sv
// 40-bit mantissa adder/subtractor
// three carry groups: 32..39, 16..31 and 0..15, carries run toward bit 0
// overflow compares the carries into and out of the sign bit

`timescale 1ns/100ps
`default_nettype none

module fpalu (
	input  wire logic [0:fpa_pkg::mant_w-1]  t,
	input  wire logic [0:fpa_pkg::mant_w-1]  c,
	input  wire fpa_pkg::fpa_ctl_s           ctl,
	output logic [0:fpa_pkg::mant_w-1]       sum,
	output fpa_pkg::fpa_cout_s               cout,
	output logic                             ovf
);

	logic [0:fpa_pkg::mant_w-1] a;
	logic [0:fpa_pkg::mant_w-1] b;
	logic cin;
	// group sums with their carry on top
	logic [fpa_pkg::lo_w:0] g32;
	logic [fpa_pkg::word_w:0] g16;
	logic [fpa_pkg::word_w-1:0] g1;
	logic [1:0] g0;
	// carry into the sign bit
	logic c1;

	// operand select
	// neg is 0 + ~T + 1, sub is T + ~C + 1
	assign a = ctl.neg_t ? '0 : t;
	assign b = ctl.neg_t ? ~t : (ctl.sub ? ~c : c);
	assign cin = ctl.sub | ctl.neg_t;

	// low order group, bits 32..39
	assign g32 = {1'b0, a[32:39]} + {1'b0, b[32:39]} + {{fpa_pkg::lo_w{1'b0}}, cin};

	// middle group, bits 16..31
	assign g16 = {1'b0, a[16:31]} + {1'b0, b[16:31]} + {{fpa_pkg::word_w{1'b0}}, g32[8]};

	// top group split at the sign bit
	assign g1 = {1'b0, a[1:15]} + {1'b0, b[1:15]} + {{(fpa_pkg::word_w-1){1'b0}}, g16[16]};
	assign c1 = g1[15];
	assign g0 = {1'b0, a[0]} + {1'b0, b[0]} + {1'b0, c1};

	assign sum = {g0[0], g1[14:0], g16[15:0], g32[7:0]};

	// carries above bits 32, 16 and 0
	assign cout.c32 = g32[8];
	assign cout.c16 = g16[16];
	assign cout.c0 = g0[1];

	// signed overflow
	assign ovf = g0[1] ^ c1;

endmodule

`default_nettype wire

//--- src/fpa_zp.sv
// zp output bus and flag latch
// zp shows one piece of T, flags are latched at the end of an operation
// v and c are captured during the adder cycle, before T is overwritten

`timescale 1ns/100ps
`default_nettype none

module fpa_zp (
	input  wire logic                          clk_sys,
	input  wire logic                          rst_n,
	input  wire logic                          flag_ld,
	input  wire logic                          ar,
	input  wire logic [0:fpa_pkg::mant_w-1]    t,
	input  wire fpa_pkg::fpa_cout_s            cout,
	input  wire logic                          ovf,
	input  wire fpa_pkg::fpa_part_e            zp_part,
	output logic [0:fpa_pkg::word_w-1]         zp,
	output fpa_pkg::fpa_flags_s                flags
);

	// adder carry and overflow held over from the sum cycle
	logic v_hold;
	logic c_hold;

	// piece select, purely combinational from T
	always_comb begin
		case (zp_part)
			fpa_pkg::part_hi: zp = t[0:fpa_pkg::word_w-1];
			fpa_pkg::part_mid: zp = t[fpa_pkg::word_w:2*fpa_pkg::word_w-1];
			// left-justified, low byte zero
			fpa_pkg::part_lo: zp = {t[2*fpa_pkg::word_w:fpa_pkg::mant_w-1], 8'h00};
			default: zp = '0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			v_hold <= 1'b0;
			c_hold <= 1'b0;
			flags <= '0;
		end else begin
			// ar without flag_ld marks the adder cycle
			if (ar && !flag_ld) begin
				v_hold <= ovf;
				c_hold <= cout.c0;
			end
			if (flag_ld) begin
				flags.z <= ~|t;
				flags.m <= t[0];
				// normalize leaves v and c clear
				flags.v <= ar & v_hold;
				flags.c <= ar & c_hold;
			end
		end
	end

endmodule

`default_nettype wire

//--- src/fpa_unit.sv
// top of the mantissa arithmetic unit
// load T and C in pieces over w, pulse start with op, wait for done,
// then read T back piece by piece on zp along with the flags

`timescale 1ns/100ps
`default_nettype none

module fpa_unit (
	input  wire logic                          clk_sys,
	input  wire logic                          rst_n,
	input  wire logic [0:fpa_pkg::word_w-1]    w,
	input  wire fpa_pkg::fpa_part_e            w_part,
	input  wire logic                          t_ld,
	input  wire logic                          c_ld,
	input  wire logic                          start,
	input  wire fpa_pkg::fpa_op_e              op,
	input  wire fpa_pkg::fpa_part_e            zp_part,
	output logic [0:fpa_pkg::word_w-1]         zp,
	output fpa_pkg::fpa_flags_s                flags,
	output logic                               busy,
	output logic                               done,
	output logic [fpa_pkg::cnt_w-1:0]          norm_cnt
);

	fpa_pkg::fpa_ctl_s ctl;
	fpa_pkg::fpa_cout_s cout;
	logic [0:fpa_pkg::mant_w-1] t;
	logic [0:fpa_pkg::mant_w-1] c;
	logic [0:fpa_pkg::mant_w-1] sum;
	logic t_wr;
	logic c_wr;
	logic t_zero;
	logic ovf;

	// sequencer
	fpa_ctl i_fpa_ctl (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.start(start),
		.op(op),
		.t_ld(t_ld),
		.c_ld(c_ld),
		// top two bits of T steer normalize
		.t0(t[0]),
		.t1(t[1]),
		.t_zero(t_zero),
		.ctl(ctl),
		.t_wr(t_wr),
		.c_wr(c_wr),
		.busy(busy),
		.done(done),
		.norm_cnt(norm_cnt)
	);

	// operand registers
	fpa_regs i_fpa_regs (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.ctl(ctl),
		.t_wr(t_wr),
		.c_wr(c_wr),
		.w(w),
		.w_part(w_part),
		.sum(sum),
		.t(t),
		.c(c),
		.t_zero(t_zero)
	);

	// mantissa adder
	fpalu i_fpalu (
		.t(t),
		.c(c),
		.ctl(ctl),
		.sum(sum),
		.cout(cout),
		.ovf(ovf)
	);

	// result bus and flags
	fpa_zp i_fpa_zp (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.flag_ld(ctl.flag_ld),
		.ar(ctl.ar),
		.t(t),
		.cout(cout),
		.ovf(ovf),
		.zp_part(zp_part),
		.zp(zp),
		.flags(flags)
	);

endmodule

`default_nettype wire

//--- dv/fpa_unit_tb.sv
// self-checking testbench for the mantissa unit
// vectors come from dv/fpa_stim.txt, run from the project root
// each one loads T and C, runs the op and checks zp, flags and norm_cnt

`timescale 1ns/100ps
`default_nettype none

module fpa_unit_tb;

	localparam int rst_cycles = 16;
	// cycle budget per test, longest normalize fits well inside
	localparam int test_cycles = 64;

	// one line of the stim file, mantissas as plain numbers
	typedef struct packed {
		logic [1:0] op;
		logic [fpa_pkg::mant_w-1:0] t;
		logic [fpa_pkg::mant_w-1:0] c;
		logic [fpa_pkg::mant_w-1:0] r;
		logic [3:0] flags;
		logic [fpa_pkg::cnt_w-1:0] cnt;
	} vec_s;

	logic clk_sys = 1'b0;
	logic rst_n;
	logic [15:0] w;
	fpa_pkg::fpa_part_e w_part;
	logic t_ld;
	logic c_ld;
	logic start;
	fpa_pkg::fpa_op_e op;
	fpa_pkg::fpa_part_e zp_part;
	logic [15:0] zp;
	fpa_pkg::fpa_flags_s flags;
	logic busy;
	logic done;
	logic [fpa_pkg::cnt_w-1:0] norm_cnt;

	vec_s vecs[$];
	int errs = 0;
	int pass_cnt = 0;
	int fail_cnt = 0;
	int cycles = 0;
	int cycle_limit = rst_cycles + test_cycles;

	fpa_unit i_fpa_unit (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.w(w),
		.w_part(w_part),
		.t_ld(t_ld),
		.c_ld(c_ld),
		.start(start),
		.op(op),
		.zp_part(zp_part),
		.zp(zp),
		.flags(flags),
		.busy(busy),
		.done(done),
		.norm_cnt(norm_cnt)
	);

	always #4 clk_sys = ~clk_sys;

	// watchdog, limit is raised once the vectors are counted
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("run stopped after %0d cycles, the DUT stopped responding", cycles);
			$display("=== FAIL ===");
			$finish;
		end
	end

	task automatic compare(input string what, input logic [39:0] got, input logic [39:0] exp);
		if (got !== exp) begin
			$display("mismatch at %0.1f ns: %s is %h, expected %h", $realtime, what, got, exp);
			errs++;
		end
	endtask

	task automatic finish_test(input string name);
		if (errs == 0) begin
			$display("%s: ok", name);
			pass_cnt++;
		end else begin
			$display("%s: %0d errors", name, errs);
			fail_cnt++;
		end
		errs = 0;
	endtask

	task automatic read_stim();
		int fd;
		int n;
		int cn;
		logic [8*160-1:0] line;
		logic [15:0] f [0:9];
		logic [3:0] fl;
		vec_s v;
		fd = $fopen("dv/fpa_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open dv/fpa_stim.txt");
			fail_cnt++;
		end else begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				// comment lines do not scan and are skipped
				if (n > 0) begin
					n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %b %d",
						f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], fl, cn);
					if (n == 12) begin
						v.op = f[0][1:0];
						v.t = {f[1], f[2], f[3][7:0]};
						v.c = {f[4], f[5], f[6][7:0]};
						v.r = {f[7], f[8], f[9][7:0]};
						v.flags = fl;
						v.cnt = cn[fpa_pkg::cnt_w-1:0];
						vecs.push_back(v);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic load_piece(input logic to_c, input fpa_pkg::fpa_part_e part,
		input logic [15:0] d);
		w = d;
		w_part = part;
		t_ld = !to_c;
		c_ld = to_c;
		@(negedge clk_sys);
		t_ld = 1'b0;
		c_ld = 1'b0;
	endtask

	// hi, mid, then the low byte left-justified
	task automatic load_mant(input logic to_c, input logic [39:0] v);
		load_piece(to_c, fpa_pkg::part_hi, v[39:24]);
		load_piece(to_c, fpa_pkg::part_mid, v[23:8]);
		load_piece(to_c, fpa_pkg::part_lo, {v[7:0], 8'h00});
	endtask

	task automatic read_piece(input fpa_pkg::fpa_part_e part, output logic [15:0] d);
		zp_part = part;
		@(negedge clk_sys);
		d = zp;
	endtask

	// T over zp, all three pieces
	task automatic check_t(input string what, input logic [39:0] exp);
		logic [15:0] d;
		read_piece(fpa_pkg::part_hi, d);
		compare({what, " hi"}, d, exp[39:24]);
		read_piece(fpa_pkg::part_mid, d);
		compare({what, " mid"}, d, exp[23:8]);
		read_piece(fpa_pkg::part_lo, d);
		compare({what, " lo"}, d, {exp[7:0], 8'h00});
	endtask

	// pulse start, wait for done, lat is edges from start to done
	task automatic run_op(input fpa_pkg::fpa_op_e o, input logic poke_c, output int lat);
		start = 1'b1;
		op = o;
		@(negedge clk_sys);
		start = 1'b0;
		lat = 0;
		while (!done && lat < test_cycles) begin
			compare("busy during op", busy, 1'b1);
			// C load in the first busy cycle must be dropped
			if (poke_c && lat == 0) begin
				c_ld = 1'b1;
				w = 16'hdead;
				w_part = fpa_pkg::part_hi;
			end else begin
				c_ld = 1'b0;
			end
			@(negedge clk_sys);
			lat++;
		end
		c_ld = 1'b0;
		if (!done) begin
			$display("operation never finished");
			errs++;
		end else begin
			compare("busy at done", busy, 1'b0);
			@(negedge clk_sys);
			compare("done pulse width", done, 1'b0);
		end
	endtask

	initial begin : main
		vec_s v;
		int lat;
		int i;
		int unsigned gap;
		logic [39:0] t_val;
		logic [39:0] c_val;
		rst_n = 1'b0;
		w = '0;
		w_part = fpa_pkg::part_hi;
		t_ld = 1'b0;
		c_ld = 1'b0;
		start = 1'b0;
		op = fpa_pkg::op_add;
		zp_part = fpa_pkg::part_hi;
		gap = $urandom(32'he15d21e0);
		read_stim();
		if (vecs.size() == 0) begin
			$display("stim file holds no vectors");
			fail_cnt++;
		end
		// two fixed tests plus one per vector
		cycle_limit = rst_cycles + (vecs.size() + 2) * test_cycles;
		repeat (rst_cycles) @(negedge clk_sys);
		rst_n = 1'b1;

		compare("busy after reset", busy, 1'b0);
		compare("done after reset", done, 1'b0);
		compare("flags after reset", flags, 4'b0000);
		compare("norm_cnt after reset", norm_cnt, 0);
		check_t("T after reset", 40'h0);
		finish_test("reset state");

		// add with a stray C load, then sub must give T back
		t_val = 40'h01_2345_6789;
		c_val = 40'h00_1111_2222;
		load_mant(1'b0, t_val);
		load_mant(1'b1, c_val);
		run_op(fpa_pkg::op_add, 1'b1, lat);
		compare("add latency", lat, 2);
		check_t("T plus C", t_val + c_val);
		run_op(fpa_pkg::op_sub, 1'b0, lat);
		check_t("T plus C minus C", t_val);
		finish_test("load while busy");

		for (i = 0; i < vecs.size(); i++) begin
			v = vecs[i];
			load_mant(1'b0, v.t);
			load_mant(1'b1, v.c);
			check_t("loaded T", v.t);
			run_op(fpa_pkg::fpa_op_e'(v.op), 1'b0, lat);
			// normalize latency depends on the data
			if (v.op != 2'd3) begin
				compare("done latency", lat, 2);
			end
			check_t("result", v.r);
			compare("flags", flags, v.flags);
			compare("norm_cnt", norm_cnt, v.cnt);
			finish_test($sformatf("vector %0d op %0d", i, v.op));
			gap = $urandom % 4;
			repeat (gap) @(negedge clk_sys);
		end

		$display("%0d tests passed, %0d failed", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/fpa_stim.txt
# op t_hi t_mid t_lo c_hi c_mid c_lo r_hi r_mid r_lo zmvc cnt
# hex except zmvc (binary flags) and cnt (decimal); op 0 add 1 sub 2 neg 3 norm; lo = bits 32..39
0 0000 ffff ff 0000 0000 01 0001 0000 00 0000 0
0 ffff ffff ff 0000 0000 01 0000 0000 00 1001 0
0 7fff ffff ff 0000 0000 01 8000 0000 00 0110 0
0 8000 0000 00 8000 0000 00 0000 0000 00 1011 0
0 1234 5678 9a 0fed cba9 87 2222 2222 21 0000 0
1 0000 0000 03 0000 0000 05 ffff ffff fe 0100 0
1 1234 5678 9a 1234 5678 9a 0000 0000 00 1001 0
1 8000 0000 00 0000 0000 01 7fff ffff ff 0011 0
1 0001 0000 00 0000 0000 01 0000 ffff ff 0001 0
2 0000 0000 01 abcd ef01 23 ffff ffff ff 0100 0
2 8000 0000 00 abcd ef01 23 8000 0000 00 0110 0
2 0000 0000 00 abcd ef01 23 0000 0000 00 1001 0
2 1234 5678 9a abcd ef01 23 edcb a987 66 0100 0
3 0000 0000 00 0000 0000 00 0000 0000 00 1000 0
3 0000 0000 01 0000 0000 00 4000 0000 00 0000 38
3 ffff ffff ff 0000 0000 00 8000 0000 00 0100 39
3 f000 0000 00 0000 0000 00 8000 0000 00 0100 3
3 0012 3456 78 0000 0000 00 48d1 59e0 00 0000 10
3 ff12 3456 78 0000 0000 00 891a 2b3c 00 0100 7

//--- filelist.f
src/fpa_pkg.sv
src/fpa_ctl.sv
src/fpa_regs.sv
src/fpalu.sv
src/fpa_zp.sv
src/fpa_unit.sv
dv/fpa_unit_tb.sv

//--- Bender.yml
package:
  name: fpa_unit

sources:
  # mantissa unit RTL, package first
  - files:
      - src/fpa_pkg.sv
      - src/fpa_ctl.sv
      - src/fpa_regs.sv
      - src/fpalu.sv
      - src/fpa_zp.sv
      - src/fpa_unit.sv
  # testbench
  - target: test
    files:
      - dv/fpa_unit_tb.sv
